//--- list.f
+incdir+common
common/ex1Pkg.sv
verilog/opDecode.sv
verilog/addrGen.sv
verilog/gprWriteback.sv
verilog/ctrlWriteback.sv
verilog/memIssue.sv
verilog/ex1Stage.sv
testbench/clockGen.sv
testbench/ex1Tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex1Tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJDIR)

//--- testbench/ex1Tb.sv
/*
 * EX1 stage testbench: seeded random ops, reference model,
 * typed compare tasks, cycle timeout and error summary
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module ex1Tb;

	// test lengths in cycles
	localparam int gprOps = 200;
	localparam int memOps = 150;
	localparam int braOps = 100;
	localparam int flagOps = 100;
	localparam int unkOps = 40;
	localparam int cycleLimit = gprOps + memOps + braOps + flagOps + unkOps + 50;

	logic clock;
	logic rstN;

	// DUT inputs
	logic                  opValid;
	logic [7:0]            opUCmd;
	logic [7:0]            opUIxt;
	ex1Pkg::regIdT         regIdRm;
	ex1Pkg::wordT          regValRs;
	ex1Pkg::wordT          regValRt;
	ex1Pkg::wordT          regValRm;
	logic [`EX1_IMM_W-1:0] regValImm;
	ex1Pkg::addrT          regValPc;
	ex1Pkg::wordT          regInSr;
	ex1Pkg::addrT          regInLr;
	ex1Pkg::wordT          regInDlr;
	logic                  opBraFlush;
	logic                  memBusy;

	// DUT outputs
	wire                   exHold;
	wire                   resValid;
	ex1Pkg::regIdT         gprId;
	ex1Pkg::wordT          gprVal;
	ex1Pkg::wordT          srOut;
	ex1Pkg::addrT          lrOut;
	wire                   braValid;
	ex1Pkg::addrT          braAddr;
	ex1Pkg::trapT          trapExc;
	ex1Pkg::addrT          memAddr;
	ex1Pkg::memOpmT        memOpm;
	ex1Pkg::wordT          memData;

	// model predictions for the op in flight
	logic           expHold;
	logic           expValid;
	ex1Pkg::regIdT  expId;
	ex1Pkg::wordT   expVal;
	ex1Pkg::wordT   expSr;
	ex1Pkg::addrT   expLr;
	logic           expBra;
	ex1Pkg::addrT   expBraAddr;
	ex1Pkg::trapT   expTrap;
	ex1Pkg::addrT   expAddr;
	ex1Pkg::memOpmT expOpm;
	ex1Pkg::wordT   expData;
	logic           pending;

	integer       seed = 32'h08018d5b;
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;
	string        testName = "reset";
	ex1Pkg::wordT srState;

	clockGen clockGen_i (.clock(clock), .rstN(rstN));

	ex1Stage ex1Stage_i (
		.clock(clock), .rstN(rstN), .opValid(opValid), .opUCmd(opUCmd),
		.opUIxt(opUIxt), .regIdRm(regIdRm), .regValRs(regValRs),
		.regValRt(regValRt), .regValRm(regValRm), .regValImm(regValImm),
		.regValPc(regValPc), .regInSr(regInSr), .regInLr(regInLr),
		.regInDlr(regInDlr), .opBraFlush(opBraFlush), .memBusy(memBusy),
		.exHold(exHold), .resValid(resValid), .gprId(gprId), .gprVal(gprVal),
		.srOut(srOut), .lrOut(lrOut), .braValid(braValid), .braAddr(braAddr),
		.trapExc(trapExc), .memAddr(memAddr), .memOpm(memOpm), .memData(memData)
	);

	// hard stop if the stimulus never finishes
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout: run exceeded %0d cycles without finishing", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic checkBit(input string sig, input logic want, input logic got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s %s: expected %b, actual %b", testName, sig, want, got);
		end
	endtask

	task automatic checkHold(input bit want);
		checkBit("exHold", want, exHold);
	endtask

	task automatic checkGpr(input ex1Pkg::regIdT wantId, input ex1Pkg::wordT wantVal);
		checks++;
		if (gprId !== wantId) begin
			errors++;
			$display("mismatch %s gprId: expected %h, actual %h", testName, wantId, gprId);
		end else if (wantId != `EX1_GR_ZZR && gprVal !== wantVal) begin
			errors++;
			$display("mismatch %s gprVal: expected %h, actual %h", testName, wantVal, gprVal);
		end
	endtask

	task automatic checkCtrl(input ex1Pkg::wordT wantSr, input ex1Pkg::addrT wantLr,
		input ex1Pkg::trapT wantTrap, input bit wantBra, input ex1Pkg::addrT wantBraAddr);
		checks++;
		if (srOut !== wantSr) begin
			errors++;
			$display("mismatch %s srOut: expected %h, actual %h", testName, wantSr, srOut);
		end
		if (lrOut !== wantLr) begin
			errors++;
			$display("mismatch %s lrOut: expected %h, actual %h", testName, wantLr, lrOut);
		end
		if (trapExc !== wantTrap) begin
			errors++;
			$display("mismatch %s trapExc: expected %h, actual %h", testName, wantTrap, trapExc);
		end
		checkBit("braValid", wantBra, braValid);
		// target only meaningful with a branch
		if (wantBra && braAddr !== wantBraAddr) begin
			errors++;
			$display("mismatch %s braAddr: expected %h, actual %h", testName, wantBraAddr,
				braAddr);
		end
	endtask

	task automatic checkMem(input ex1Pkg::addrT wantAddr, input ex1Pkg::memOpmT wantOpm,
		input ex1Pkg::wordT wantData);
		checks++;
		if (wantOpm.dir == ex1Pkg::memReady) begin
			// an idle request is judged on its direction alone
			if (memOpm.dir !== ex1Pkg::memReady) begin
				errors++;
				$display("mismatch %s memOpm.dir: expected %h, actual %h", testName,
					wantOpm.dir, memOpm.dir);
			end
		end else begin
			if (memOpm !== wantOpm) begin
				errors++;
				$display("mismatch %s memOpm: expected %h, actual %h", testName, wantOpm, memOpm);
			end
			if (memAddr !== wantAddr) begin
				errors++;
				$display("mismatch %s memAddr: expected %h, actual %h", testName, wantAddr,
					memAddr);
			end
			if (wantOpm.dir == ex1Pkg::memStore && memData !== wantData) begin
				errors++;
				$display("mismatch %s memData: expected %h, actual %h", testName, wantData,
					memData);
			end
		end
	endtask

	// registered outputs forced idle by a reset edge
	task automatic expectResetState();
		checkBit("resValid", 1'b0, resValid);
		checkBit("braValid", 1'b0, braValid);
		checkBit("trapExc nonzero", 1'b0, trapExc != '0);
		checkBit("memOpm.dir not ready", 1'b0, memOpm.dir != ex1Pkg::memReady);
		checkGpr(`EX1_GR_ZZR, '0);
	endtask

	// one op of each result kind in turn
	task automatic driveResetOp(input int step);
		opValid = 1'b1;
		opUIxt = {2'b0, `IXT_TRAPA};
		case (step % 4)
			0: opUCmd = {`CC_AL, `UCMD_LEA};
			1: opUCmd = {`CC_AL, `UCMD_STORE};
			2: opUCmd = {`CC_AL, `UCMD_IXT};
			default: opUCmd = {`CC_AL, `UCMD_BRA};
		endcase
	endtask

	// reference model for the op on the inputs right now
	task automatic predict();
		logic         pass;
		logic         t;
		logic         known;
		logic         fire;
		logic [5:0]   code;
		logic [5:0]   sub;
		ex1Pkg::addrT memA;
		ex1Pkg::addrT disp;
		code = opUCmd[5:0];
		sub = opUIxt[5:0];
		t = regInSr[0];
		case (opUCmd[7:6])
			`CC_AL:  pass = 1'b1;
			`CC_NV:  pass = 1'b0;
			`CC_CT:  pass = t;
			default: pass = !t;
		endcase
		if (opBraFlush)
			pass = 1'b0;
		case (code)
			`UCMD_MOVIR: known = sub <= `MOVIR_LDISH32;
			`UCMD_IXS:   known = sub <= `IXS_MOVNT;
			`UCMD_IXT:   known = sub <= `IXT_BREAK;
			default:     known = code <= `UCMD_JSR;
		endcase
		expHold = opValid && (!known || (code == `UCMD_IXT && sub == `IXT_BREAK) ||
			((code == `UCMD_LOAD || code == `UCMD_STORE) && pass && memBusy));
		fire = opValid && pass && !expHold;
		memA = regValRs[47:0] + (regValRt[47:0] << opUIxt[5:4]);
		disp = {{15{regValImm[32]}}, regValImm};
		// idle defaults with SR and LR echoed
		expValid = fire;
		expId = `EX1_GR_ZZR;
		expVal = '0;
		expSr = regInSr;
		expLr = regInLr;
		expBra = 1'b0;
		expBraAddr = '0;
		expTrap = '0;
		expAddr = memA;
		expData = regValRm;
		expOpm.dir = ex1Pkg::memReady;
		expOpm.signExt = opUIxt[2];
		expOpm.size = opUIxt[5:4];
		if (fire) begin
			case (code)
				`UCMD_LEA: begin
					expId = regIdRm;
					expVal = {16'h0, memA};
				end
				`UCMD_LOAD:  expOpm.dir = ex1Pkg::memLoad;
				`UCMD_STORE: expOpm.dir = ex1Pkg::memStore;
				`UCMD_MOVIR: begin
					expId = regIdRm;
					case (sub)
						`MOVIR_LDI:     expVal = {{31{regValImm[32]}}, regValImm};
						`MOVIR_LDISH8:  expVal = {regValRs[55:0], regValImm[7:0]};
						`MOVIR_LDISH16: expVal = {regValRs[47:0], regValImm[15:0]};
						default:        expVal = {regValRs[31:0], regValImm[31:0]};
					endcase
				end
				`UCMD_BRA, `UCMD_BSR, `UCMD_JMP, `UCMD_JSR: begin
					expBra = 1'b1;
					expBraAddr = (code == `UCMD_BRA || code == `UCMD_BSR) ?
						regValPc + (disp << 1) : regValRs[47:0];
					if (code == `UCMD_BSR || code == `UCMD_JSR)
						expLr = regValPc;
				end
				`UCMD_IXS: begin
					if (sub != `IXS_NOP) begin
						expId = regIdRm;
						expVal = {63'h0, (sub == `IXS_MOVNT) ? !t : t};
					end
				end
				`UCMD_IXT: begin
					case (sub)
						`IXT_CLRT:  expSr[0] = 1'b0;
						`IXT_SETT:  expSr[0] = 1'b1;
						`IXT_CLRS:  expSr[1] = 1'b0;
						`IXT_SETS:  expSr[1] = 1'b1;
						`IXT_NOTT:  expSr[0] = !t;
						`IXT_NOTS:  expSr[1] = !regInSr[1];
						`IXT_TRAPA: expTrap = {`TRAP_TRAPA, regIdRm[3:0]};
						`IXT_SYSE:  expTrap = {`TRAP_SYSE, regInDlr[11:0]};
						default:    ;
					endcase
				end
				default: ;
			endcase
		end
	endtask

	// results of the previous op are settled by the falling edge
	task automatic beginCycle();
		@(negedge clock);
		if (pending) begin
			checkBit("resValid", expValid, resValid);
			checkGpr(expId, expVal);
			checkCtrl(expSr, expLr, expTrap, expBra, expBraAddr);
			checkMem(expAddr, expOpm, expData);
		end
	endtask

	task automatic issue();
		predict();
		pending = 1'b1;
		#1;
		checkHold(expHold);
	endtask

	task automatic randOperands();
		logic [31:0] r;
		r = rand32();
		regIdRm = r[5:0];
		regValRs = {rand32(), rand32()};
		regValRt = {rand32(), rand32()};
		regValRm = {rand32(), rand32()};
		regValImm = {r[6], rand32()};
		regValPc = {r[23:8], rand32()};
		r = rand32();
		regInLr = {r[15:0], rand32()};
		regInSr = {rand32(), rand32()};
		regInDlr = {rand32(), rand32()};
	endtask

	// random condition code, rare flush, rare bubble
	task automatic randCond(input logic [5:0] code);
		logic [31:0] r;
		r = rand32();
		opUCmd = {r[1:0], code};
		opBraFlush = (r[5:2] == 4'h0);
		opValid = (r[9:6] != 4'h0);
	endtask

	initial begin
		logic [31:0] r;
		logic [5:0]  code;
		logic        held;
		int          step;
		opValid = 1'b0;
		opUCmd = '0;
		opUIxt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValImm = '0;
		regValPc = '0;
		regInSr = '0;
		regInLr = '0;
		regInDlr = '0;
		opBraFlush = 1'b0;
		memBusy = 1'b0;
		pending = 1'b0;
		expHold = 1'b0;

		// live ops sit on the inputs while reset is low
		step = 0;
		do begin
			driveResetOp(step);
			@(posedge clock);
			held = !rstN;
			@(negedge clock);
			if (held)
				expectResetState();
			step++;
		end while (held);
		opValid = 1'b0;

		// LEA, MOV_IR forms, MOVT/MOVNT and NOP
		testName = "gpr";
		for (int i = 0; i < gprOps; i++) begin
			beginCycle();
			randOperands();
			r = rand32();
			case (r[2:0])
				3'd0: code = `UCMD_LEA;
				3'd5, 3'd6: code = `UCMD_IXS;
				3'd7: code = `UCMD_NOP;
				default: code = `UCMD_MOVIR;
			endcase
			randCond(code);
			if (code == `UCMD_MOVIR)
				opUIxt = {6'h0, r[4:3]};
			else if (code == `UCMD_IXS)
				opUIxt = (r[2:0] == 3'd5) ? {2'b0, `IXS_MOVT} : {2'b0, `IXS_MOVNT};
			else
				opUIxt = r[15:8];
			issue();
		end

		// a held op is presented again until memory is free
		testName = "memory";
		for (int i = 0; i < memOps; i++) begin
			beginCycle();
			r = rand32();
			if (!expHold) begin
				randOperands();
				randCond(r[0] ? `UCMD_STORE : `UCMD_LOAD);
				opUIxt = r[15:8];
			end
			memBusy = (r[17:16] == 2'b00);
			issue();
		end
		memBusy = 1'b0;

		// every fourth op sits near the top of the address space
		testName = "branch";
		for (int i = 0; i < braOps; i++) begin
			beginCycle();
			randOperands();
			r = rand32();
			randCond(`UCMD_BRA + {4'h0, r[1:0]});
			opUIxt = r[15:8];
			if (r[3:2] == 2'b00) begin
				regValPc = {32'hFFFF_FFFF, r[31:16]};
				regValImm[32] = 1'b0;
			end
			issue();
		end

		// SR fed back so flag ops chain
		testName = "flags";
		srState = {rand32(), rand32()};
		for (int i = 0; i < flagOps; i++) begin
			beginCycle();
			randOperands();
			r = rand32();
			randCond(`UCMD_IXT);
			opUIxt = {2'b0, {3'h0, r[2:0]} + 6'd1};
			regInSr = srState;
			issue();
			srState = expSr;
		end

		// each unhandled op shown for two cycles
		testName = "unhandled";
		for (int i = 0; i < unkOps; i++) begin
			beginCycle();
			if (i % 2 == 0) begin
				randOperands();
				r = rand32();
				case (r[1:0])
					2'd0: code = 6'h0B + {1'b0, r[6:2]};
					2'd1: code = `UCMD_MOVIR;
					2'd2: code = `UCMD_IXS;
					default: code = `UCMD_IXT;
				endcase
				randCond(code);
				opValid = 1'b1;
				if (code == `UCMD_MOVIR)
					opUIxt = {2'b0, {3'h0, r[4:2]} + 6'd4};
				else if (code == `UCMD_IXS)
					opUIxt = {2'b0, {3'h0, r[4:2]} + 6'd3};
				else if (r[2])
					opUIxt = {2'b0, `IXT_BREAK};
				else
					opUIxt = {2'b0, {3'h0, r[5:3]} + 6'd10};
			end
			issue();
		end

		beginCycle();
		opValid = 1'b0;
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
/*
 * testbench clock (4 ns period) and synchronous reset,
 * held low for the first 3 rising edges
 */
`timescale 1ns/100ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic rstN
);

	localparam int halfPeriod = 2;
	localparam int resetCycles = 3;

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = !clock;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/ex1Stage.sv
/*
 * EX1 stage top: decode, address generation and the three
 * registered writeback paths (GPR, control, memory request)
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module ex1Stage (
	input  wire                       clock,
	input  wire                       rstN,
	input  wire                       opValid,
	input  wire [7:0]                 opUCmd,
	input  wire [7:0]                 opUIxt,
	input  ex1Pkg::regIdT             regIdRm,
	input  ex1Pkg::wordT              regValRs,
	input  ex1Pkg::wordT              regValRt,
	input  ex1Pkg::wordT              regValRm,
	input  wire [`EX1_IMM_W-1:0]      regValImm,
	input  ex1Pkg::addrT              regValPc,
	input  ex1Pkg::wordT              regInSr,
	input  ex1Pkg::addrT              regInLr,
	input  ex1Pkg::wordT              regInDlr,
	input  wire                       opBraFlush,
	input  wire                       memBusy,
	output wire                       exHold,
	output wire                       resValid,
	output ex1Pkg::regIdT             gprId,
	output ex1Pkg::wordT              gprVal,
	output ex1Pkg::wordT              srOut,
	output ex1Pkg::addrT              lrOut,
	output wire                       braValid,
	output ex1Pkg::addrT              braAddr,
	output ex1Pkg::trapT              trapExc,
	output ex1Pkg::addrT              memAddr,
	output ex1Pkg::memOpmT            memOpm,
	output ex1Pkg::wordT              memData
);

	// decode results shared by all writeback paths
	ex1Pkg::opClassT opClass;
	wire [5:0]       opSub;
	wire             opFire;
	wire             pcRel;
	ex1Pkg::addrT    agAddr;

	opDecode opDecode_i (
		.clock(clock), .rstN(rstN), .opValid(opValid), .opUCmd(opUCmd),
		.opUIxt(opUIxt), .srT(regInSr[0]), .opBraFlush(opBraFlush),
		.memBusy(memBusy), .opClass(opClass), .opSub(opSub), .opFire(opFire),
		.exHold(exHold), .resValid(resValid), .pcRel(pcRel)
	);

	// scale comes from opUIxt[5:4]
	addrGen addrGen_i (
		.base(regValRs), .index(regValRt), .scale(opUIxt[5:4]),
		.pc(regValPc), .imm(regValImm), .pcRel(pcRel), .agAddr(agAddr)
	);

	gprWriteback gprWriteback_i (
		.clock(clock), .rstN(rstN), .opFire(opFire), .opClass(opClass),
		.opSub(opSub), .regIdRm(regIdRm), .regValRs(regValRs),
		.regValImm(regValImm), .agAddr(agAddr), .srT(regInSr[0]),
		.gprId(gprId), .gprVal(gprVal)
	);

	ctrlWriteback ctrlWriteback_i (
		.clock(clock), .rstN(rstN), .opFire(opFire), .opClass(opClass),
		.opSub(opSub), .opUCmd5(opUCmd[5:0]), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValPc(regValPc), .regInSr(regInSr),
		.regInLr(regInLr), .regInDlr(regInDlr), .agAddr(agAddr),
		.srOut(srOut), .lrOut(lrOut), .braValid(braValid),
		.braAddr(braAddr), .trapExc(trapExc)
	);

	memIssue memIssue_i (
		.clock(clock), .rstN(rstN), .opFire(opFire), .opClass(opClass),
		.opSub(opSub), .agAddr(agAddr), .regValRm(regValRm),
		.memAddr(memAddr), .memOpm(memOpm), .memData(memData)
	);

endmodule

`default_nettype wire

//--- verilog/memIssue.sv
/*
 * load/store request: address, op mode and store data,
 * registered toward the memory stage
 */
`timescale 1ns/100ps
`default_nettype none

module memIssue (
	input  wire             clock,
	input  wire             rstN,
	input  wire             opFire,
	input  ex1Pkg::opClassT opClass,
	input  wire [5:0]       opSub,
	input  ex1Pkg::addrT    agAddr,
	input  ex1Pkg::wordT    regValRm,
	output ex1Pkg::addrT    memAddr,
	output ex1Pkg::memOpmT  memOpm,
	output ex1Pkg::wordT    memData
);

	ex1Pkg::memOpmT nextOpm;
	wire            isLoad;
	wire            isStore;

	assign isLoad = opFire && (opClass == ex1Pkg::opLoad);
	assign isStore = opFire && (opClass == ex1Pkg::opStore);

	// sign extend in opUIxt[2], size in opUIxt[5:4]
	always_comb begin
		nextOpm.dir = ex1Pkg::memReady;
		nextOpm.signExt = opSub[2];
		nextOpm.size = opSub[5:4];
		if (isLoad)
			nextOpm.dir = ex1Pkg::memLoad;
		else if (isStore)
			nextOpm.dir = ex1Pkg::memStore;
	end

	always_ff @(posedge clock) begin
		if (!rstN)
			memOpm <= '{dir: ex1Pkg::memReady, signExt: 1'b0, size: 2'b00};
		else
			memOpm <= nextOpm;
	end

	// address and data only load on a real request
	always_ff @(posedge clock) begin
		if (isLoad || isStore)
			memAddr <= agAddr;
		if (isStore)
			memData <= regValRm;
	end

	// reserved direction must never reach memory
	dirLegal: assert property (@(posedge clock) disable iff (!rstN)
		memOpm.dir != 2'b11);

endmodule

`default_nettype wire

//--- verilog/ctrlWriteback.sv
/*
 * control results: SR flag ops, LR on calls, branch target
 * and trap codes, all registered
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module ctrlWriteback (
	input  wire             clock,
	input  wire             rstN,
	input  wire             opFire,
	input  ex1Pkg::opClassT opClass,
	input  wire [5:0]       opSub,
	input  wire [5:0]       opUCmd5,
	input  ex1Pkg::regIdT   regIdRm,
	input  ex1Pkg::wordT    regValRs,
	input  ex1Pkg::addrT    regValPc,
	input  ex1Pkg::wordT    regInSr,
	input  ex1Pkg::addrT    regInLr,
	input  ex1Pkg::wordT    regInDlr,
	input  ex1Pkg::addrT    agAddr,
	output ex1Pkg::wordT    srOut,
	output ex1Pkg::addrT    lrOut,
	output logic            braValid,
	output ex1Pkg::addrT    braAddr,
	output ex1Pkg::trapT    trapExc
);

	ex1Pkg::wordT nextSr;
	ex1Pkg::addrT nextLr;
	ex1Pkg::addrT nextBraAddr;
	ex1Pkg::trapT nextTrap;
	logic         nextBra;

	always_comb begin
		// default is to echo SR and LR
		nextSr = regInSr;
		nextLr = regInLr;
		nextBra = 1'b0;
		nextBraAddr = agAddr;
		nextTrap = '0;
		if (opFire && opClass == ex1Pkg::opBranch) begin
			nextBra = 1'b1;
			// calls save the PC
			if (opUCmd5 == `UCMD_BSR || opUCmd5 == `UCMD_JSR)
				nextLr = regValPc;
			// register-indirect jumps
			if (opUCmd5 == `UCMD_JMP || opUCmd5 == `UCMD_JSR)
				nextBraAddr = regValRs[`EX1_ADDR_W-1:0];
		end
		if (opFire && opClass == ex1Pkg::opIxt) begin
			// T is bit 0, S is bit 1
			case (opSub)
				`IXT_CLRT:  nextSr[0] = 1'b0;
				`IXT_SETT:  nextSr[0] = 1'b1;
				`IXT_CLRS:  nextSr[1] = 1'b0;
				`IXT_SETS:  nextSr[1] = 1'b1;
				`IXT_NOTT:  nextSr[0] = !regInSr[0];
				`IXT_NOTS:  nextSr[1] = !regInSr[1];
				`IXT_TRAPA: nextTrap = {`TRAP_TRAPA, regIdRm[3:0]};
				`IXT_SYSE:  nextTrap = {`TRAP_SYSE, regInDlr[11:0]};
				default:    ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			braValid <= 1'b0;
			trapExc <= '0;
		end else begin
			braValid <= nextBra;
			trapExc <= nextTrap;
		end
	end

	always_ff @(posedge clock) begin
		srOut <= nextSr;
		lrOut <= nextLr;
		braAddr <= nextBraAddr;
	end

	// a branch and a trap never leave in the same cycle
	braTrapExcl: assert property (@(posedge clock) disable iff (!rstN)
		!(braValid && trapExc != '0));

endmodule

`default_nettype wire

//--- verilog/gprWriteback.sv
/*
 * general register result: LEA, MOV_IR forms and MOVT/MOVNT,
 * registered toward the register file
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module gprWriteback (
	input  wire                  clock,
	input  wire                  rstN,
	input  wire                  opFire,
	input  ex1Pkg::opClassT      opClass,
	input  wire [5:0]            opSub,
	input  ex1Pkg::regIdT        regIdRm,
	input  ex1Pkg::wordT         regValRs,
	input  wire [`EX1_IMM_W-1:0] regValImm,
	input  ex1Pkg::addrT         agAddr,
	input  wire                  srT,
	output ex1Pkg::regIdT        gprId,
	output ex1Pkg::wordT         gprVal
);

	ex1Pkg::regIdT nextId;
	ex1Pkg::wordT  nextVal;

	always_comb begin
		nextId = regIdRm;
		nextVal = {{(`EX1_WORD_W-`EX1_ADDR_W){1'b0}}, agAddr};
		case (opClass)
			ex1Pkg::opLea: ;
			ex1Pkg::opMovir: begin
				case (opSub)
					`MOVIR_LDISH8:  nextVal = {regValRs[55:0], regValImm[7:0]};
					`MOVIR_LDISH16: nextVal = {regValRs[47:0], regValImm[15:0]};
					`MOVIR_LDISH32: nextVal = {regValRs[31:0], regValImm[31:0]};
					// plain LDI, sign from bit 32
					default: nextVal = {{(`EX1_WORD_W-`EX1_IMM_W){regValImm[32]}},
						regValImm};
				endcase
			end
			ex1Pkg::opIxs: begin
				nextVal = {{(`EX1_WORD_W-1){1'b0}}, (opSub == `IXS_MOVNT) ? !srT : srT};
				if (opSub == `IXS_NOP)
					nextId = `EX1_GR_ZZR;
			end
			default: nextId = `EX1_GR_ZZR;
		endcase
		// predicated off, flushed or held
		if (!opFire)
			nextId = `EX1_GR_ZZR;
	end

	always_ff @(posedge clock) begin
		if (!rstN)
			gprId <= `EX1_GR_ZZR;
		else
			gprId <= nextId;
	end

	// value only matters with a real id
	always_ff @(posedge clock)
		gprVal <= nextVal;

endmodule

`default_nettype wire

//--- verilog/addrGen.sv
/*
 * address generation: scaled base+index for memory ops and LEA,
 * PC plus doubled displacement for BRA/BSR
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module addrGen (
	input  ex1Pkg::wordT         base,
	input  ex1Pkg::wordT         index,
	input  wire [1:0]            scale,
	input  ex1Pkg::addrT         pc,
	input  wire [`EX1_IMM_W-1:0] imm,
	input  wire                  pcRel,
	output ex1Pkg::addrT         agAddr
);

	ex1Pkg::addrT scaledIdx;
	ex1Pkg::addrT dispX2;

	// index scaled by element size, truncated to 48 bits
	assign scaledIdx = index[`EX1_ADDR_W-1:0] << scale;

	// sign extend the 33-bit displacement and double it
	assign dispX2 = {{(`EX1_ADDR_W-`EX1_IMM_W-1){imm[`EX1_IMM_W-1]}}, imm, 1'b0};

	// both sums wrap at 48 bits
	assign agAddr = pcRel ? (pc + dispX2) : (base[`EX1_ADDR_W-1:0] + scaledIdx);

endmodule

`default_nettype wire

//--- verilog/opDecode.sv
/*
 * predication, op classification, hold generation and
 * the registered result-valid strobe
 */
`timescale 1ns/100ps
`default_nettype none

`include "ex1Defs.svh"

module opDecode (
	input  wire             clock,
	input  wire             rstN,
	input  wire             opValid,
	input  wire [7:0]       opUCmd,
	input  wire [7:0]       opUIxt,
	input  wire             srT,
	input  wire             opBraFlush,
	input  wire             memBusy,
	output ex1Pkg::opClassT opClass,
	output wire [5:0]       opSub,
	output wire             opFire,
	output wire             exHold,
	output logic            resValid,
	output wire             pcRel
);

	logic predPass;
	logic known;
	wire  isBreak;
	wire  isMem;

	assign opSub = opUIxt[5:0];

	// condition code against SR.T, a flush kills everything
	always_comb begin
		case (opUCmd[7:6])
			`CC_AL:  predPass = 1'b1;
			`CC_NV:  predPass = 1'b0;
			`CC_CT:  predPass = srT;
			default: predPass = !srT;
		endcase
		if (opBraFlush)
			predPass = 1'b0;
	end

	// class plus whether the sub-op is one we handle
	always_comb begin
		opClass = ex1Pkg::opNone;
		known = 1'b1;
		case (opUCmd[5:0])
			`UCMD_NOP:   opClass = ex1Pkg::opNone;
			`UCMD_LEA:   opClass = ex1Pkg::opLea;
			`UCMD_LOAD:  opClass = ex1Pkg::opLoad;
			`UCMD_STORE: opClass = ex1Pkg::opStore;
			`UCMD_MOVIR: begin
				opClass = ex1Pkg::opMovir;
				known = opSub inside {`MOVIR_LDI, `MOVIR_LDISH8,
					`MOVIR_LDISH16, `MOVIR_LDISH32};
			end
			`UCMD_BRA, `UCMD_BSR, `UCMD_JMP, `UCMD_JSR:
				opClass = ex1Pkg::opBranch;
			`UCMD_IXS: begin
				opClass = ex1Pkg::opIxs;
				known = opSub inside {`IXS_NOP, `IXS_MOVT, `IXS_MOVNT};
			end
			`UCMD_IXT: begin
				opClass = ex1Pkg::opIxt;
				known = opSub <= `IXT_BREAK;
			end
			default: known = 1'b0;
		endcase
	end

	assign isBreak = (opClass == ex1Pkg::opIxt) && (opSub == `IXT_BREAK);
	assign isMem = (opClass == ex1Pkg::opLoad) || (opClass == ex1Pkg::opStore);

	// unknown ops and BREAK stall regardless of predicate
	assign exHold = opValid && (!known || isBreak || (isMem && predPass && memBusy));
	assign opFire = opValid && predPass && !exHold;

	// BRA and BSR use the PC-relative adder
	assign pcRel = (opUCmd[5:0] == `UCMD_BRA) || (opUCmd[5:0] == `UCMD_BSR);

	always_ff @(posedge clock) begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= opFire;
	end

	// a held op never shows a result on the next cycle
	holdNoResult: assert property (@(posedge clock) disable iff (!rstN)
		exHold |=> !resValid);

endmodule

`default_nettype wire

//--- common/ex1Pkg.sv
/*
 * shared EX1 types: register values, addresses, register ids,
 * memory op mode, op class and trap code
 */
`default_nettype none

`include "ex1Defs.svh"

package ex1Pkg;

	// general register value
	typedef logic [`EX1_WORD_W-1:0] wordT;

	// virtual address, 48 bits
	typedef logic [`EX1_ADDR_W-1:0] addrT;

	// register id, ZZR means no write
	typedef logic [`EX1_REGID_W-1:0] regIdT;

	// request direction, 11 is never issued
	typedef enum logic [1:0] {
		memReady = 2'b00,
		memLoad  = 2'b01,
		memStore = 2'b10
	} memDirT;

	// dir, sign extend, size (byte/word/long/quad)
	typedef struct packed {
		memDirT     dir;
		logic       signExt;
		logic [1:0] size;
	} memOpmT;

	// coarse op class out of decode
	typedef enum logic [2:0] {
		opNone,
		opLea,
		opLoad,
		opStore,
		opMovir,
		opBranch,
		opIxs,
		opIxt
	} opClassT;

	// trap code, zero when no trap
	typedef logic [15:0] trapT;

endpackage

`default_nettype wire

//--- common/ex1Defs.svh
/*
 * widths, micro-op codes, IXS/IXT/MOV_IR sub-op codes,
 * condition codes and trap prefixes for the EX1 stage
 */
`ifndef EX1_DEFS_SVH
`define EX1_DEFS_SVH

`define EX1_WORD_W   64
`define EX1_ADDR_W   48
`define EX1_REGID_W  6
`define EX1_IMM_W    33

// register id that means no write
`define EX1_GR_ZZR   6'h3F

// micro-op codes, opUCmd[5:0]
`define UCMD_NOP     6'h00
`define UCMD_LEA     6'h01
`define UCMD_LOAD    6'h02
`define UCMD_STORE   6'h03
`define UCMD_MOVIR   6'h04
`define UCMD_BRA     6'h05
`define UCMD_BSR     6'h06
`define UCMD_JMP     6'h07
`define UCMD_JSR     6'h08
`define UCMD_IXS     6'h09
`define UCMD_IXT     6'h0A

// MOV_IR forms, opUIxt[5:0]
`define MOVIR_LDI     6'h00
`define MOVIR_LDISH8  6'h01
`define MOVIR_LDISH16 6'h02
`define MOVIR_LDISH32 6'h03

// IXS sub-ops
`define IXS_NOP      6'h00
`define IXS_MOVT     6'h01
`define IXS_MOVNT    6'h02

// IXT sub-ops
`define IXT_NOP      6'h00
`define IXT_CLRT     6'h01
`define IXT_SETT     6'h02
`define IXT_CLRS     6'h03
`define IXT_SETS     6'h04
`define IXT_NOTT     6'h05
`define IXT_NOTS     6'h06
`define IXT_TRAPA    6'h07
`define IXT_SYSE     6'h08
`define IXT_BREAK    6'h09

// condition codes, opUCmd[7:6]
`define CC_AL        2'b00
`define CC_NV        2'b01
`define CC_CT        2'b10
`define CC_CF        2'b11

// trap code prefixes
`define TRAP_TRAPA   12'hC08
`define TRAP_SYSE    4'hE

`endif
